// File: xt_periph.f
+incdir+hdl
+incdir+test
hdl/xt_periph_pkg.sv
hdl/io_decoder.sv
hdl/ems_mapper.sv
hdl/timer_clock_gen.sv
hdl/io_readback.sv
hdl/xt_periph_top.sv
test/xt_periph_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= xt_periph_tb
FILELIST  ?= xt_periph.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// File: test/xt_periph_cases.txt
// kind addr data cfg expect, kind 1 io write, 2 io read, 3 decode, 4 window, 5 pclk pulses
// data is strobe control {aen,mem_wr,mem_rd,io_wr,io_rd} for kinds 3 and 4, F ends the list
2 00378 00 4 1FF
3 00000 01 4 040
3 00085 01 4 020
3 00021 02 4 010
3 00043 01 4 008
3 00061 01 4 004
3 00040 11 4 000
3 00040 04 4 000
3 00140 01 4 000
3 F0000 04 4 002
3 FFFFF 08 4 002
3 EC000 04 4 001
3 E8000 04 4 000
2 00260 00 4 1FF
1 00260 12 4 000
2 00260 00 4 112
1 00261 7F 4 000
2 00261 00 4 17F
1 00262 05 4 000
1 00263 40 4 000
2 00263 00 4 140
1 00260 85 4 000
2 00260 00 4 112
1 00261 FF 4 000
2 00261 00 4 1FF
2 00262 00 0 000
4 A0000 04 4 092
4 A4000 04 4 000
4 A8000 08 4 205
4 AC000 04 4 440
4 AC000 01 4 000
4 AC000 14 4 000
4 C8000 04 5 205
4 A8000 04 5 000
4 DC000 04 6 440
4 D0000 04 6 092
1 00378 A5 4 000
1 00262 33 4 000
2 00378 00 4 1A5
2 00262 00 4 133
2 00379 00 4 000
2 00264 00 4 000
2 00040 00 4 000
5 00003 00 4 001
5 00002 00 4 001
5 00001 00 4 000
F 00000 00 0 000

// File: test/xt_periph_checks.svh
// Compare tasks and bus-cycle drivers for the peripheral glue testbench
// Included inside the testbench module and uses its bus and config signals

`ifndef XT_PERIPH_CHECKS_SVH
`define XT_PERIPH_CHECKS_SVH

task automatic abort_run(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
endtask

task automatic check_data(input logic [`XT_DATA_W-1:0] got, input logic got_valid,
                          input logic [`XT_DATA_W-1:0] exp, input logic exp_valid);
    if (got_valid !== exp_valid) begin
        abort_run($sformatf("mismatch at %0t: data_valid_o got %b expected %b",
                            $time, got_valid, exp_valid));
    end else if (got !== exp) begin
        abort_run($sformatf("mismatch at %0t: data_o got %h expected %h", $time, got, exp));
    end
endtask

task automatic check_dev_sel(input xt_periph_pkg::dev_sel_t got,
                             input xt_periph_pkg::dev_sel_t exp);
    if (got !== exp) begin
        abort_run($sformatf("mismatch at %0t: dev_sel_o got %b expected %b", $time, got, exp));
    end
endtask

task automatic check_hits(input logic [`XT_EMS_PAGES-1:0] got_hit,
                          input logic [`XT_EMS_MAP_W-1:0] got_page,
                          input logic [`XT_EMS_PAGES-1:0] exp_hit,
                          input logic [`XT_EMS_MAP_W-1:0] exp_page);
    if (got_hit !== exp_hit) begin
        abort_run($sformatf("mismatch at %0t: ems_hit_o got %b expected %b",
                            $time, got_hit, exp_hit));
    end else if (got_page !== exp_page) begin
        abort_run($sformatf("mismatch at %0t: ems_page_o got %h expected %h",
                            $time, got_page, exp_page));
    end
endtask

task automatic check_timer(input logic got, input logic exp);
    if (got !== exp) begin
        abort_run($sformatf("mismatch at %0t: timer_clock_o got %b expected %b",
                            $time, got, exp));
    end
endtask

// Idle cycle with no strobe and random address and data
task automatic drive_idle();
    logic [31:0] r;
    r = next_random();
    bus = '0;
    bus.addr  = r[31:12];
    bus.wdata = r[11:4];
endtask

// ctrl is {aen, mem_wr, mem_rd, io_wr, io_rd}
task automatic drive_strobe(input logic [`XT_ADDR_W-1:0] addr,
                            input logic [`XT_DATA_W-1:0] wdata, input logic [4:0] ctrl);
    bus = '0;
    bus.addr   = addr;
    bus.wdata  = wdata;
    bus.io_rd  = ctrl[0];
    bus.io_wr  = ctrl[1];
    bus.mem_rd = ctrl[2];
    bus.mem_wr = ctrl[3];
    bus.aen    = ctrl[4];
endtask

`endif

// File: test/xt_periph_tb.sv
// PC/XT peripheral glue testbench
// Replays the case file against the top level and checks each response

`timescale 1ns/10ps
`default_nettype none

`include "xt_periph_config.svh"

module xt_periph_tb;

    localparam int CLK_PERIOD = 4;
    localparam int MAX_CASES  = 64;
    localparam int FIELDS     = 5;

    logic                       clock;
    logic                       reset;
    xt_periph_pkg::bus_cycle_t  bus;
    xt_periph_pkg::ems_cfg_t    ems_cfg;
    logic                       peripheral_clock;
    xt_periph_pkg::dev_sel_t    dev_sel;
    logic [`XT_EMS_PAGES-1:0]   ems_hit;
    logic [`XT_EMS_MAP_W-1:0]   ems_page;
    logic [`XT_DATA_W-1:0]      rd_data;
    logic                       data_valid;
    logic                       timer_clock;
    logic [23:0]                case_mem [MAX_CASES*FIELDS];
    int                         n_cases;
    logic [31:0]                lcg_state;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

`include "xt_periph_checks.svh"

    xt_periph_top u_xt_periph_top (
        .clock              (clock),
        .reset              (reset),
        .bus_i              (bus),
        .ems_cfg_i          (ems_cfg),
        .peripheral_clock_i (peripheral_clock),
        .dev_sel_o          (dev_sel),
        .ems_hit_o          (ems_hit),
        .ems_page_o         (ems_page),
        .data_o             (rd_data),
        .data_valid_o       (data_valid),
        .timer_clock_o      (timer_clock)
    );

    always #(CLK_PERIOD/2) clock = ~clock;

    // Pulses of 4 cycles high and 4 low followed by 4 settle cycles
    task automatic pulse_peripheral_clock(input logic [`XT_ADDR_W-1:0] count);
        drive_idle();
        repeat (count) begin
            peripheral_clock = 1'b1;
            repeat (4) @(negedge clock);
            peripheral_clock = 1'b0;
            repeat (4) @(negedge clock);
        end
        repeat (4) @(negedge clock);
    endtask

    task automatic run_case(input int idx);
        logic [3:0]            kind;
        logic [`XT_ADDR_W-1:0] addr;
        logic [7:0]            data_f;
        logic [2:0]            cfg_f;
        logic [10:0]           exp;
        logic [31:0]           r;
        int                    gap;
        kind   = case_mem[idx*FIELDS][3:0];
        addr   = case_mem[idx*FIELDS+1][19:0];
        data_f = case_mem[idx*FIELDS+2][7:0];
        cfg_f  = case_mem[idx*FIELDS+3][2:0];
        exp    = case_mem[idx*FIELDS+4][10:0];
        r      = next_random();
        @(negedge clock);
        ems_cfg.enabled = cfg_f[2];
        ems_cfg.base    = xt_periph_pkg::ems_base_e'(cfg_f[1:0]);
        case (kind)
            4'h1: begin
                drive_strobe(addr, data_f, 5'b00010);
                @(negedge clock);
                drive_idle();
            end
            4'h2: begin
                drive_strobe(addr, r[7:0], 5'b00001);
                @(negedge clock);
                drive_idle();
                check_data(rd_data, data_valid, exp[7:0], exp[8]);
            end
            4'h3: begin
                drive_strobe(addr, r[7:0], data_f[4:0]);
                #1;
                check_dev_sel(dev_sel, xt_periph_pkg::dev_sel_t'(exp[6:0]));
                @(negedge clock);
                drive_idle();
            end
            4'h4: begin
                drive_strobe(addr, r[7:0], data_f[4:0]);
                #1;
                check_hits(ems_hit, ems_page, exp[10:7], exp[6:0]);
                @(negedge clock);
                drive_idle();
            end
            4'h5: begin
                pulse_peripheral_clock(addr);
                check_timer(timer_clock, exp[0]);
            end
            default: abort_run($sformatf("case %0d has an unknown kind %h", idx, kind));
        endcase
        gap = 1 + int'(r[29:28]);
        repeat (gap) begin
            @(negedge clock);
            drive_idle();
        end
    endtask

    initial begin
        clock            = 1'b0;
        reset            = 1'b1;
        bus              = '0;
        ems_cfg          = '0;
        peripheral_clock = 1'b0;
        lcg_state        = 32'd22;
        n_cases          = 0;
        $readmemh("test/xt_periph_cases.txt", case_mem);
        while (n_cases < MAX_CASES && case_mem[n_cases*FIELDS] == case_mem[n_cases*FIELDS]
               && case_mem[n_cases*FIELDS] != 24'hF) begin
            n_cases++;
        end
        if (n_cases == 0) begin
            abort_run("no cases could be read from the case file");
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end
        $display("TESTS PASSED");
        $finish;
    end

    // Watchdog allows 40 cycles per case
    initial begin
        wait (n_cases > 0);
        #(n_cases * 40 * CLK_PERIOD);
        abort_run("timeout: the case sequence did not finish in time");
    end

endmodule

`default_nettype wire

// File: hdl/xt_periph_top.sv
// PC/XT peripheral glue top level
// Decoder, EMS mapper, timer clock generator and chipset read-back

`timescale 1ns/10ps
`default_nettype none

`include "xt_periph_config.svh"

module xt_periph_top (
    input  wire                            clock,
    input  wire                            reset,
    input  var xt_periph_pkg::bus_cycle_t  bus_i,
    input  var xt_periph_pkg::ems_cfg_t    ems_cfg_i,
    input  wire                            peripheral_clock_i,
    output xt_periph_pkg::dev_sel_t        dev_sel_o,
    output logic [`XT_EMS_PAGES-1:0]       ems_hit_o,
    output logic [`XT_EMS_MAP_W-1:0]       ems_page_o,
    output logic [`XT_DATA_W-1:0]          data_o,
    output logic                           data_valid_o,
    output logic                           timer_clock_o
);

    xt_periph_pkg::reg_sel_t  reg_sel;
    logic [`XT_DATA_W-1:0]    ems_rdata;

    io_decoder u_io_decoder (
        .bus_i       (bus_i),
        .ems_cfg_i   (ems_cfg_i),
        .dev_sel_o   (dev_sel_o),
        .reg_sel_o   (reg_sel)
    );

    ems_mapper u_ems_mapper (
        .clock       (clock),
        .reset       (reset),
        .bus_i       (bus_i),
        .ems_cfg_i   (ems_cfg_i),
        .ems_sel_i   (reg_sel.ems),
        .ems_rdata_o (ems_rdata),
        .ems_hit_o   (ems_hit_o),
        .ems_page_o  (ems_page_o)
    );

    timer_clock_gen u_timer_clock_gen (
        .clock              (clock),
        .reset              (reset),
        .peripheral_clock_i (peripheral_clock_i),
        .timer_clock_o      (timer_clock_o)
    );

    io_readback u_io_readback (
        .clock        (clock),
        .reset        (reset),
        .bus_i        (bus_i),
        .reg_sel_i    (reg_sel),
        .ems_rdata_i  (ems_rdata),
        .data_o       (data_o),
        .data_valid_o (data_valid_o)
    );

endmodule

`default_nettype wire

// File: hdl/io_readback.sv
// Chipset read-back path
// LPT data latch and the registered multiplexer onto the data bus

`timescale 1ns/10ps
`default_nettype none

`include "xt_periph_config.svh"

module io_readback (
    input  wire                            clock,
    input  wire                            reset,
    input  var xt_periph_pkg::bus_cycle_t  bus_i,
    input  var xt_periph_pkg::reg_sel_t    reg_sel_i,
    input  wire  [`XT_DATA_W-1:0]          ems_rdata_i,
    output logic [`XT_DATA_W-1:0]          data_o,
    output logic                           data_valid_o
);

    xt_periph_pkg::rd_src_e  rd_src;
    logic [`XT_DATA_W-1:0]   lpt_data_q;

    // Printer data register, idles high like an empty port
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lpt_data_q <= '1;
        end else if (reg_sel_i.lpt && bus_i.io_wr) begin
            lpt_data_q <= bus_i.wdata;
        end
    end

    // EMS wins if both ever match
    always_comb begin
        rd_src = xt_periph_pkg::RD_NONE;
        if (bus_i.io_rd) begin
            if (reg_sel_i.ems) begin
                rd_src = xt_periph_pkg::RD_EMS;
            end else if (reg_sel_i.lpt) begin
                rd_src = xt_periph_pkg::RD_LPT;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_o       <= '0;
            data_valid_o <= 1'b0;
        end else begin
            case (rd_src)
                xt_periph_pkg::RD_EMS: begin
                    data_o       <= ems_rdata_i;
                    data_valid_o <= 1'b1;
                end
                xt_periph_pkg::RD_LPT: begin
                    data_o       <= lpt_data_q;
                    data_valid_o <= 1'b1;
                end
                default: begin
                    data_o       <= '0;
                    data_valid_o <= 1'b0;
                end
            endcase
        end
    end

    // Read data only ever answers a read strobe one clock earlier
    assert property (@(posedge clock) disable iff (reset) data_valid_o |-> $past(bus_i.io_rd))
        else $error("io_readback: data valid without a preceding read");

endmodule

`default_nettype wire

// File: hdl/timer_clock_gen.sv
// Timer clock generator
// Synchronizes the peripheral clock and toggles the timer clock on each rise

`timescale 1ns/10ps
`default_nettype none

module timer_clock_gen (
    input  wire  clock,
    input  wire  reset,
    input  wire  peripheral_clock_i,
    output logic timer_clock_o
);

    logic sync_1;
    logic sync_2;
    logic sync_prev;
    logic rise;

    // Two-flop synchronizer plus edge history
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sync_1    <= 1'b0;
            sync_2    <= 1'b0;
            sync_prev <= 1'b0;
        end else begin
            sync_1    <= peripheral_clock_i;
            sync_2    <= sync_1;
            sync_prev <= sync_2;
        end
    end

    assign rise = sync_2 & ~sync_prev;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            timer_clock_o <= 1'b0;
        end else if (rise) begin
            timer_clock_o <= ~timer_clock_o;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ems_mapper.sv
// EMS page mapper
// Four page-map registers at 260h..263h and the memory-window hit decode

`timescale 1ns/10ps
`default_nettype none

`include "xt_periph_config.svh"

module ems_mapper (
    input  wire                            clock,
    input  wire                            reset,
    input  var xt_periph_pkg::bus_cycle_t  bus_i,
    input  var xt_periph_pkg::ems_cfg_t    ems_cfg_i,
    input  wire                            ems_sel_i,
    output logic [`XT_DATA_W-1:0]          ems_rdata_o,
    output logic [`XT_EMS_PAGES-1:0]       ems_hit_o,
    output logic [`XT_EMS_MAP_W-1:0]       ems_page_o
);

    localparam int PAGES = `XT_EMS_PAGES;
    localparam int MAP_W = `XT_EMS_MAP_W;
    localparam int IDX_W = $clog2(PAGES);

    typedef enum logic [1:0] {
        OP_NONE,
        OP_MAP,
        OP_DISABLE
    } ems_op_e;

    ems_op_e             op_d;
    ems_op_e             op_q;
    logic [IDX_W-1:0]    idx_q;
    logic [MAP_W-1:0]    map_data_q;
    logic [MAP_W-1:0]    page_map_q [PAGES];
    logic [PAGES-1:0]    page_ena_q;
    logic [IDX_W-1:0]    rd_idx;
    logic [3:0]          base_nib;
    logic                mem_cyc;

    // Data 80h..FEh leaves the page alone
    always_comb begin
        op_d = OP_NONE;
        if (ems_sel_i && bus_i.io_wr) begin
            if (bus_i.wdata == `XT_EMS_DISABLE) begin
                op_d = OP_DISABLE;
            end else if (!bus_i.wdata[7]) begin
                op_d = OP_MAP;
            end
        end
    end

    // Capture stage
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            op_q <= OP_NONE;
        end else begin
            op_q <= op_d;
        end
    end

    always_ff @(posedge clock) begin
        idx_q      <= bus_i.addr[IDX_W-1:0];
        map_data_q <= bus_i.wdata[MAP_W-1:0];
    end

    // Update stage
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int n = 0; n < PAGES; n++) begin
                page_map_q[n] <= '0;
            end
            page_ena_q <= '0;
        end else begin
            case (op_q)
                OP_MAP: begin
                    page_map_q[idx_q] <= map_data_q;
                    page_ena_q[idx_q] <= 1'b1;
                end
                OP_DISABLE: begin
                    page_map_q[idx_q] <= '1;
                    page_ena_q[idx_q] <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    assign rd_idx      = bus_i.addr[IDX_W-1:0];
    assign ems_rdata_o = page_ena_q[rd_idx] ? {1'b0, page_map_q[rd_idx]} : `XT_EMS_DISABLE;

    // Unknown base encodings fall back to D000
    always_comb begin
        case (ems_cfg_i.base)
            xt_periph_pkg::EMS_BASE_A000: base_nib = 4'hA;
            xt_periph_pkg::EMS_BASE_C000: base_nib = 4'hC;
            default:                      base_nib = 4'hD;
        endcase
    end

    assign mem_cyc = (bus_i.mem_rd | bus_i.mem_wr) & ~bus_i.aen;

    always_comb begin
        ems_page_o = '0;
        for (int n = 0; n < PAGES; n++) begin
            ems_hit_o[n] = mem_cyc & page_ena_q[n]
                         & (bus_i.addr[19:14] == {base_nib, IDX_W'(n)});
            if (ems_hit_o[n]) begin
                ems_page_o = page_map_q[n];
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset) $onehot0(ems_hit_o))
        else $error("ems_mapper: overlapping window hits");

endmodule

`default_nettype wire

// File: hdl/io_decoder.sv
// I/O and memory decoder
// Turns a bus cycle into external device selects and chipset register selects

`timescale 1ns/10ps
`default_nettype none

`include "xt_periph_config.svh"

module io_decoder (
    input  var xt_periph_pkg::bus_cycle_t bus_i,
    input  var xt_periph_pkg::ems_cfg_t   ems_cfg_i,
    output xt_periph_pkg::dev_sel_t       dev_sel_o,
    output xt_periph_pkg::reg_sel_t       reg_sel_o
);

    localparam logic [15:0] DMA_BASE      = `XT_DMA_BASE;
    localparam logic [15:0] PIC_BASE      = `XT_PIC_BASE;
    localparam logic [15:0] PIT_BASE      = `XT_PIT_BASE;
    localparam logic [15:0] PPI_BASE      = `XT_PPI_BASE;
    localparam logic [15:0] DMA_PAGE_BASE = `XT_DMA_PAGE_BASE;
    localparam logic [15:0] EMS_PORT      = `XT_EMS_PORT;
    localparam logic [15:0] LPT_PORT      = `XT_LPT_PORT;
    localparam logic [`XT_ADDR_W-1:0] BIOS_BASE  = `XT_BIOS_BASE;
    localparam logic [`XT_ADDR_W-1:0] XTIDE_BASE = `XT_XTIDE_BASE;

    // Device block match on address bits 7:5
    function automatic logic blk_match(input logic [`XT_ADDR_W-1:0] addr,
                                       input logic [15:0] base);
        return addr[7:5] == base[7:5];
    endfunction

    logic iorq;
    logic memrq;
    logic io_dev;

    assign iorq   = (bus_i.io_rd | bus_i.io_wr) & ~bus_i.aen;
    assign memrq  = (bus_i.mem_rd | bus_i.mem_wr) & ~bus_i.aen;
    // Motherboard devices live below 100h
    assign io_dev = iorq & (bus_i.addr[9:8] == 2'b00);

    always_comb begin
        dev_sel_o.dma      = io_dev & blk_match(bus_i.addr, DMA_BASE);
        dev_sel_o.pic      = io_dev & blk_match(bus_i.addr, PIC_BASE);
        dev_sel_o.pit      = io_dev & blk_match(bus_i.addr, PIT_BASE);
        dev_sel_o.ppi      = io_dev & blk_match(bus_i.addr, PPI_BASE);
        dev_sel_o.dma_page = io_dev & blk_match(bus_i.addr, DMA_PAGE_BASE);
        dev_sel_o.bios     = memrq & (bus_i.addr[19:16] == BIOS_BASE[19:16]);
        dev_sel_o.xtide    = memrq & (bus_i.addr[19:14] == XTIDE_BASE[19:14]);

        assert ($onehot0(dev_sel_o))
            else $error("io_decoder: more than one device select active");
    end

    // 260h..263h, only while EMS is switched on
    assign reg_sel_o.ems = iorq & ems_cfg_i.enabled
                         & (bus_i.addr[15:2] == EMS_PORT[15:2]);
    assign reg_sel_o.lpt = iorq & (bus_i.addr[15:0] == LPT_PORT);

endmodule

`default_nettype wire

// File: hdl/xt_periph_pkg.sv
// PC/XT peripheral glue types
// Bus cycle, select and configuration structs shared by the glue blocks

`default_nettype none

`include "xt_periph_config.svh"

package xt_periph_pkg;

    // One bus cycle, strobes active high for a single clock
    typedef struct packed {
        logic [`XT_ADDR_W-1:0] addr;
        logic [`XT_DATA_W-1:0] wdata;
        logic                  io_rd;
        logic                  io_wr;
        logic                  mem_rd;
        logic                  mem_wr;
        logic                  aen;
    } bus_cycle_t;

    // Selects for the external chips
    typedef struct packed {
        logic dma;
        logic dma_page;
        logic pic;
        logic pit;
        logic ppi;
        logic bios;
        logic xtide;
    } dev_sel_t;

    // Chipset registers addressed by an I/O cycle
    typedef struct packed {
        logic ems;
        logic lpt;
    } reg_sel_t;

    typedef enum logic [1:0] {
        EMS_BASE_A000 = 2'd0,
        EMS_BASE_C000 = 2'd1,
        EMS_BASE_D000 = 2'd2
    } ems_base_e;

    typedef struct packed {
        logic      enabled;
        ems_base_e base;
    } ems_cfg_t;

    typedef enum logic [1:0] {
        RD_NONE,
        RD_EMS,
        RD_LPT
    } rd_src_e;

endpackage

`default_nettype wire

// File: hdl/xt_periph_config.svh
// PC/XT peripheral glue configuration
// Bus widths, I/O port addresses, memory windows and EMS constants

`ifndef XT_PERIPH_CONFIG_SVH
`define XT_PERIPH_CONFIG_SVH

// Bus widths
`define XT_ADDR_W           20
`define XT_DATA_W           8

// Chipset register ports
`define XT_EMS_PORT         16'h0260
`define XT_LPT_PORT         16'h0378

// External device port bases, decoded on bits 7:5
`define XT_DMA_BASE         16'h0000
`define XT_PIC_BASE         16'h0020
`define XT_PIT_BASE         16'h0040
`define XT_PPI_BASE         16'h0060
`define XT_DMA_PAGE_BASE    16'h0080

// ROM windows
`define XT_BIOS_BASE        20'hF0000
`define XT_XTIDE_BASE       20'hEC000

// EMS page registers
`define XT_EMS_PAGES        4
`define XT_EMS_MAP_W        7
`define XT_EMS_DISABLE      8'hFF

`endif
